//--- src/sb_pkg.sv
`default_nettype none

package sb_pkg;

    localparam int SB_ADDR_W = 32;
    localparam int SB_DATA_W = 32;
    localparam int SB_FIFO_DEPTH = 4;

    // register map, byte addresses on the AXI4-Lite port.
    localparam logic [SB_ADDR_W-1:0] REG_RX_DATA_LO = 32'h0000_0000;
    localparam logic [SB_ADDR_W-1:0] REG_RX_DATA_HI = 32'h0000_0004;
    localparam logic [SB_ADDR_W-1:0] REG_RX_DEST = 32'h0000_0008;
    localparam logic [SB_ADDR_W-1:0] REG_RX_PUSH = 32'h0000_000C;  // bit 0 carries last.
    localparam logic [SB_ADDR_W-1:0] REG_TX_DATA_LO = 32'h0000_0010;
    localparam logic [SB_ADDR_W-1:0] REG_TX_DATA_HI = 32'h0000_0014;
    localparam logic [SB_ADDR_W-1:0] REG_TX_DEST = 32'h0000_0018;
    localparam logic [SB_ADDR_W-1:0] REG_TX_STATUS = 32'h0000_001C;
    localparam logic [SB_ADDR_W-1:0] REG_TX_POP = 32'h0000_0020;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // byte 0 of data sits in bits 7:0.
    typedef struct packed {
        logic [63:0] data;
        logic [31:0] dest;
        logic last;
    } sb_packet_t;

endpackage

`default_nettype wire

//--- src/sb_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sb_fifo #(
    parameter int DEPTH = sb_pkg::SB_FIFO_DEPTH
) (
    input logic clk,
    input logic rst,
    input sb_pkg::sb_packet_t in_pkt,
    input logic in_valid,
    output logic in_ready,
    output sb_pkg::sb_packet_t out_pkt,
    output logic out_valid,
    input logic out_ready
);

    sb_pkg::sb_packet_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic push;
    logic pop;

    assign in_ready = int'(count) < DEPTH;
    assign out_valid = count != '0;
    assign out_pkt = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (push) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

endmodule

`default_nettype wire

//--- src/sb_byte_incr.sv
`timescale 1ns/100ps
`default_nettype none

module sb_byte_incr (
    input logic clk,
    input logic rst,
    input sb_pkg::sb_packet_t in_pkt,
    input logic in_valid,
    output logic in_ready,
    output sb_pkg::sb_packet_t out_pkt,
    output logic out_valid,
    input logic out_ready
);

    sb_pkg::sb_packet_t incr_pkt;
    sb_pkg::sb_packet_t stage_pkt;
    logic full;

    // each byte wraps on its own, no carry into the next one.
    always_comb begin
        incr_pkt = in_pkt;
        for (int i = 0; i < $bits(in_pkt.data) / 8; i++) begin
            incr_pkt.data[i*8 +: 8] = in_pkt.data[i*8 +: 8] + 8'd1;
        end
    end

    assign in_ready = !full || out_ready;  // the stage drains while it refills.
    assign out_valid = full;
    assign out_pkt = stage_pkt;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) stage_pkt <= incr_pkt;
    end

endmodule

`default_nettype wire

//--- src/sb_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sb_axil_regs (
    input logic clk,
    input logic rst,

    input logic s_axil_awvalid,
    input logic [sb_pkg::SB_ADDR_W-1:0] s_axil_awaddr,
    output logic s_axil_awready,
    input logic s_axil_wvalid,
    input logic [sb_pkg::SB_DATA_W-1:0] s_axil_wdata,
    input logic [sb_pkg::SB_DATA_W/8-1:0] s_axil_wstrb,
    output logic s_axil_wready,
    output logic s_axil_bvalid,
    output logic [1:0] s_axil_bresp,
    input logic s_axil_bready,
    input logic s_axil_arvalid,
    input logic [sb_pkg::SB_ADDR_W-1:0] s_axil_araddr,
    output logic s_axil_arready,
    output logic s_axil_rvalid,
    output logic [sb_pkg::SB_DATA_W-1:0] s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    input logic s_axil_rready,

    output sb_pkg::sb_packet_t rx_pkt,
    output logic rx_valid,
    input logic rx_ready,
    input sb_pkg::sb_packet_t tx_pkt,
    input logic tx_valid,
    output logic tx_ready
);

    logic [sb_pkg::SB_DATA_W-1:0] stage_lo;
    logic [sb_pkg::SB_DATA_W-1:0] stage_hi;
    logic [sb_pkg::SB_DATA_W-1:0] stage_dest;
    logic stage_last;
    logic wr_fire;
    logic rd_fire;
    logic push_ok;
    logic [1:0] wr_resp;
    logic [1:0] rd_resp;
    logic [sb_pkg::SB_DATA_W-1:0] rd_data;

    // merge the enabled write bytes into the old register value.
    function automatic logic [sb_pkg::SB_DATA_W-1:0] apply_strb(
        input logic [sb_pkg::SB_DATA_W-1:0] old_val,
        input logic [sb_pkg::SB_DATA_W-1:0] new_val,
        input logic [sb_pkg::SB_DATA_W/8-1:0] strb
    );
        logic [sb_pkg::SB_DATA_W-1:0] merged;
        merged = old_val;
        for (int i = 0; i < sb_pkg::SB_DATA_W / 8; i++) begin
            if (strb[i]) merged[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return merged;
    endfunction

    assign wr_fire = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready = wr_fire;
    assign push_ok = rx_ready && !rx_valid;

    assign rx_pkt = '{data: {stage_hi, stage_lo}, dest: stage_dest, last: stage_last};
    assign tx_ready = wr_fire && (s_axil_awaddr == sb_pkg::REG_TX_POP) && tx_valid;

    always_comb begin
        wr_resp = sb_pkg::RESP_OKAY;
        case (s_axil_awaddr)
            sb_pkg::REG_RX_DATA_LO, sb_pkg::REG_RX_DATA_HI, sb_pkg::REG_RX_DEST: ;
            sb_pkg::REG_RX_PUSH: if (!push_ok) wr_resp = sb_pkg::RESP_SLVERR;
            sb_pkg::REG_TX_POP: if (!tx_valid) wr_resp = sb_pkg::RESP_SLVERR;
            default: wr_resp = sb_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_lo <= '0;
            stage_hi <= '0;
            stage_dest <= '0;
            stage_last <= 1'b0;
            rx_valid <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp <= sb_pkg::RESP_OKAY;
        end else begin
            if (rx_valid && rx_ready) rx_valid <= 1'b0;
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
                s_axil_bresp <= wr_resp;
                case (s_axil_awaddr)
                    sb_pkg::REG_RX_DATA_LO:
                        stage_lo <= apply_strb(stage_lo, s_axil_wdata, s_axil_wstrb);
                    sb_pkg::REG_RX_DATA_HI:
                        stage_hi <= apply_strb(stage_hi, s_axil_wdata, s_axil_wstrb);
                    sb_pkg::REG_RX_DEST:
                        stage_dest <= apply_strb(stage_dest, s_axil_wdata, s_axil_wstrb);
                    sb_pkg::REG_RX_PUSH: begin
                        if (push_ok) begin
                            stage_last <= s_axil_wdata[0];
                            rx_valid <= 1'b1;  // taken by the rx queue on the next cycle.
                        end
                    end
                    default: ;
                endcase
            end else if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    assign rd_fire = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = rd_fire;

    always_comb begin
        rd_data = '0;
        rd_resp = sb_pkg::RESP_OKAY;
        case (s_axil_araddr)
            sb_pkg::REG_TX_DATA_LO: if (tx_valid) rd_data = tx_pkt.data[31:0];
            sb_pkg::REG_TX_DATA_HI: if (tx_valid) rd_data = tx_pkt.data[63:32];
            sb_pkg::REG_TX_DEST: if (tx_valid) rd_data = tx_pkt.dest;
            sb_pkg::REG_TX_STATUS: rd_data[2:0] = {!rx_ready, tx_valid && tx_pkt.last, tx_valid};
            default: rd_resp = sb_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axil_rvalid <= 1'b0;
            s_axil_rdata <= '0;
            s_axil_rresp <= sb_pkg::RESP_OKAY;
        end else if (rd_fire) begin
            s_axil_rvalid <= 1'b1;
            s_axil_rdata <= rd_data;
            s_axil_rresp <= rd_resp;
        end else if (s_axil_rvalid && s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/sb_loopback.sv
`timescale 1ns/100ps
`default_nettype none

module sb_loopback (
    input logic clk,
    input logic rst,

    input logic s_axil_awvalid,
    input logic [sb_pkg::SB_ADDR_W-1:0] s_axil_awaddr,
    output logic s_axil_awready,
    input logic s_axil_wvalid,
    input logic [sb_pkg::SB_DATA_W-1:0] s_axil_wdata,
    input logic [sb_pkg::SB_DATA_W/8-1:0] s_axil_wstrb,
    output logic s_axil_wready,
    output logic s_axil_bvalid,
    output logic [1:0] s_axil_bresp,
    input logic s_axil_bready,
    input logic s_axil_arvalid,
    input logic [sb_pkg::SB_ADDR_W-1:0] s_axil_araddr,
    output logic s_axil_arready,
    output logic s_axil_rvalid,
    output logic [sb_pkg::SB_DATA_W-1:0] s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    input logic s_axil_rready
);

    sb_pkg::sb_packet_t rx_pkt;
    logic rx_valid;
    logic rx_ready;
    sb_pkg::sb_packet_t mid_pkt;
    logic mid_valid;
    logic mid_ready;
    sb_pkg::sb_packet_t inc_pkt;
    logic inc_valid;
    logic inc_ready;
    sb_pkg::sb_packet_t tx_pkt;
    logic tx_valid;
    logic tx_ready;

    sb_axil_regs regs (
        .clk(clk),
        .rst(rst),
        .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awaddr(s_axil_awaddr),
        .s_axil_awready(s_axil_awready),
        .s_axil_wvalid(s_axil_wvalid),
        .s_axil_wdata(s_axil_wdata),
        .s_axil_wstrb(s_axil_wstrb),
        .s_axil_wready(s_axil_wready),
        .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bresp(s_axil_bresp),
        .s_axil_bready(s_axil_bready),
        .s_axil_arvalid(s_axil_arvalid),
        .s_axil_araddr(s_axil_araddr),
        .s_axil_arready(s_axil_arready),
        .s_axil_rvalid(s_axil_rvalid),
        .s_axil_rdata(s_axil_rdata),
        .s_axil_rresp(s_axil_rresp),
        .s_axil_rready(s_axil_rready),
        .rx_pkt(rx_pkt),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .tx_pkt(tx_pkt),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready)
    );

    sb_fifo #(.DEPTH(sb_pkg::SB_FIFO_DEPTH)) rx_queue (
        .clk(clk),
        .rst(rst),
        .in_pkt(rx_pkt),
        .in_valid(rx_valid),
        .in_ready(rx_ready),
        .out_pkt(mid_pkt),
        .out_valid(mid_valid),
        .out_ready(mid_ready)
    );

    sb_byte_incr byte_incr (
        .clk(clk),
        .rst(rst),
        .in_pkt(mid_pkt),
        .in_valid(mid_valid),
        .in_ready(mid_ready),
        .out_pkt(inc_pkt),
        .out_valid(inc_valid),
        .out_ready(inc_ready)
    );

    sb_fifo #(.DEPTH(sb_pkg::SB_FIFO_DEPTH)) tx_queue (
        .clk(clk),
        .rst(rst),
        .in_pkt(inc_pkt),
        .in_valid(inc_valid),
        .in_ready(inc_ready),
        .out_pkt(tx_pkt),
        .out_valid(tx_valid),
        .out_ready(tx_ready)
    );

endmodule

`default_nettype wire

//--- tb/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released mid-cycle, away from the sampling edge.
    end

endmodule

`default_nettype wire

//--- tb/sb_loopback_assert.sv
`timescale 1ns/100ps
`default_nettype none

module sb_loopback_assert (
    input logic clk,
    input logic rst,
    input logic s_axil_bvalid,
    input logic s_axil_bready,
    input logic [1:0] s_axil_bresp,
    input logic s_axil_rvalid,
    input logic s_axil_rready,
    input logic [sb_pkg::SB_DATA_W-1:0] s_axil_rdata,
    input logic [1:0] s_axil_rresp,
    input sb_pkg::sb_packet_t inc_pkt,
    input logic inc_valid,
    input logic inc_ready
);

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
        else $error("rvalid or rdata changed before rready");

    resp_legal: assert property (@(posedge clk) disable iff (rst)
        (!s_axil_bvalid || s_axil_bresp == sb_pkg::RESP_OKAY
            || s_axil_bresp == sb_pkg::RESP_SLVERR)
        && (!s_axil_rvalid || s_axil_rresp == sb_pkg::RESP_OKAY
            || s_axil_rresp == sb_pkg::RESP_SLVERR))
        else $error("response code other than OKAY or SLVERR");

    // the byte increment stage must not change its packet while stalled.
    incr_stall: assert property (@(posedge clk) disable iff (rst)
        inc_valid && !inc_ready |=> $stable(inc_pkt))
        else $error("byte increment output changed under stall");

endmodule

bind sb_loopback sb_loopback_assert sb_loopback_assert_i (
    .clk(clk),
    .rst(rst),
    .s_axil_bvalid(s_axil_bvalid),
    .s_axil_bready(s_axil_bready),
    .s_axil_bresp(s_axil_bresp),
    .s_axil_rvalid(s_axil_rvalid),
    .s_axil_rready(s_axil_rready),
    .s_axil_rdata(s_axil_rdata),
    .s_axil_rresp(s_axil_rresp),
    .inc_pkt(inc_pkt),
    .inc_valid(inc_valid),
    .inc_ready(inc_ready)
);

`default_nettype wire

//--- tb/sb_loopback_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sb_loopback_tb;

    logic clk;
    logic rst;
    logic s_axil_awvalid;
    logic [sb_pkg::SB_ADDR_W-1:0] s_axil_awaddr;
    logic s_axil_awready;
    logic s_axil_wvalid;
    logic [sb_pkg::SB_DATA_W-1:0] s_axil_wdata;
    logic [sb_pkg::SB_DATA_W/8-1:0] s_axil_wstrb;
    logic s_axil_wready;
    logic s_axil_bvalid;
    logic [1:0] s_axil_bresp;
    logic s_axil_bready;
    logic s_axil_arvalid;
    logic [sb_pkg::SB_ADDR_W-1:0] s_axil_araddr;
    logic s_axil_arready;
    logic s_axil_rvalid;
    logic [sb_pkg::SB_DATA_W-1:0] s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic s_axil_rready;

    integer fd;
    integer fields;
    integer op_count;
    integer cycle_count = 0;
    integer cycle_limit = 0;
    string line;
    string op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] strb;
    logic [1:0] resp;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    sb_loopback sb_loopback_i (
        .clk(clk),
        .rst(rst),
        .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awaddr(s_axil_awaddr),
        .s_axil_awready(s_axil_awready),
        .s_axil_wvalid(s_axil_wvalid),
        .s_axil_wdata(s_axil_wdata),
        .s_axil_wstrb(s_axil_wstrb),
        .s_axil_wready(s_axil_wready),
        .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bresp(s_axil_bresp),
        .s_axil_bready(s_axil_bready),
        .s_axil_arvalid(s_axil_arvalid),
        .s_axil_araddr(s_axil_araddr),
        .s_axil_arready(s_axil_arready),
        .s_axil_rvalid(s_axil_rvalid),
        .s_axil_rdata(s_axil_rdata),
        .s_axil_rresp(s_axil_rresp),
        .s_axil_rready(s_axil_rready)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual));
        end
    endtask

    // bready is held low for one cycle, so the response has to wait for it.
    task automatic axil_write(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, output logic [1:0] r);
        @(negedge clk);
        s_axil_awaddr = a;
        s_axil_wdata = d;
        s_axil_wstrb = s;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        @(posedge clk);
        check_value("s_axil_awready", 32'(s_axil_awready), 32'd1);
        check_value("s_axil_wready", 32'(s_axil_wready), 32'd1);
        @(negedge clk);
        while (!s_axil_bvalid) @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
        @(negedge clk);
        check_value("s_axil_bvalid", 32'(s_axil_bvalid), 32'd1);
        r = s_axil_bresp;
        s_axil_bready = 1'b1;
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] a, output logic [31:0] d, output logic [1:0] r);
        @(negedge clk);
        s_axil_araddr = a;
        s_axil_arvalid = 1'b1;
        @(posedge clk);
        check_value("s_axil_arready", 32'(s_axil_arready), 32'd1);
        @(negedge clk);
        while (!s_axil_rvalid) @(negedge clk);
        s_axil_arvalid = 1'b0;
        @(negedge clk);
        check_value("s_axil_rvalid", 32'(s_axil_rvalid), 32'd1);
        d = s_axil_rdata;
        r = s_axil_rresp;
        s_axil_rready = 1'b1;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic poll_status(input logic [31:0] a);
        logic [31:0] status;
        logic [1:0] got_resp;
        status = '0;
        while (!status[0]) begin
            axil_read(a, status, got_resp);
            check_value("s_axil_rresp (status poll)", 32'(got_resp), 32'(sb_pkg::RESP_OKAY));
        end
    endtask

    task automatic run_op(input string kind, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, input logic [1:0] r);
        logic [31:0] got_data;
        logic [1:0] got_resp;
        case (kind)
            "W": begin
                axil_write(a, d, s, got_resp);
                check_value($sformatf("s_axil_bresp (addr 0x%h)", a), 32'(got_resp), 32'(r));
            end
            "R": begin
                axil_read(a, got_data, got_resp);
                check_value($sformatf("s_axil_rresp (addr 0x%h)", a), 32'(got_resp), 32'(r));
                check_value($sformatf("s_axil_rdata (addr 0x%h)", a), got_data, d);
            end
            "P": poll_status(a);
            default: abort_run($sformatf("unknown operation %s in the trace", kind));
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        s_axil_awvalid = 1'b0;
        s_axil_awaddr = '0;
        s_axil_wvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_bready = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr = '0;
        s_axil_rready = 1'b0;

        fd = $fopen("tb/sb_trace.txt", "r");
        if (fd == 0) abort_run("could not open the trace file tb/sb_trace.txt");
        op_count = 0;
        while (!$feof(fd)) begin
            op = "";
            if ($fgets(line, fd) == 0) break;
            fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, strb, resp);
            if (op.len() > 0 && op[0] != "#") op_count = op_count + 1;
        end
        $fclose(fd);
        cycle_limit = 200 * op_count + 20;  // the extra cycles cover reset.

        @(negedge clk);
        while (rst) @(negedge clk);

        fd = $fopen("tb/sb_trace.txt", "r");
        while (!$feof(fd)) begin
            op = "";
            if ($fgets(line, fd) == 0) break;
            fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, strb, resp);
            if (op.len() == 0 || op[0] == "#") continue;
            if (fields != 5) abort_run($sformatf("trace line could not be parsed: %s", line));
            run_op(op, addr, data, strb, resp);
        end
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/sb_pkg.sv
src/sb_fifo.sv
src/sb_byte_incr.sv
src/sb_axil_regs.sv
src/sb_loopback.sv
tb/clk_gen.sv
tb/sb_loopback_assert.sv
tb/sb_loopback_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
    --top-module sb_loopback_tb \
    --Mdir obj_dir \
    -f sources.f

./obj_dir/Vsb_loopback_tb 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- tb/sb_trace.txt
# op addr data wstrb resp: W writes data with wstrb and expects bresp, R expects rdata and rresp
# P polls the status register at addr until bit 0 is set, the other columns are unused
W 00000020 00000000 f 2
R 00000010 00000000 f 0
R 00000000 00000000 f 2
R 00000040 00000000 f 2
W 00000010 12345678 f 2
W 00000000 feff7f80 f 0
W 00000004 00010203 f 0
W 00000008 00000042 f 0
W 0000000c 00000001 f 0
P 0000001c 00000000 0 0
R 00000010 ff008081 f 0
R 00000014 01020304 f 0
R 00000018 00000042 f 0
R 0000001c 00000003 f 0
W 00000020 00000000 f 0
W 00000008 00000101 f 0
W 0000000c 00000000 f 0
W 00000008 00000202 f 0
W 0000000c 00000001 f 0
W 00000008 00000303 f 0
W 0000000c 00000000 f 0
P 0000001c 00000000 0 0
R 00000018 00000101 f 0
R 0000001c 00000001 f 0
R 00000010 ff008081 f 0
W 00000020 00000000 f 0
R 00000018 00000202 f 0
R 0000001c 00000003 f 0
W 00000020 00000000 f 0
R 00000018 00000303 f 0
R 0000001c 00000001 f 0
W 00000020 00000000 f 0
R 0000001c 00000000 f 0
W 00000000 aaaa1111 3 0
W 0000000c 00000000 f 0
P 0000001c 00000000 0 0
R 00000010 ff001212 f 0
R 00000014 01020304 f 0
W 00000020 00000000 f 0
W 00000008 00000901 f 0
W 0000000c 00000000 f 0
W 00000008 00000902 f 0
W 0000000c 00000000 f 0
W 00000008 00000903 f 0
W 0000000c 00000000 f 0
W 00000008 00000904 f 0
W 0000000c 00000000 f 0
W 00000008 00000905 f 0
W 0000000c 00000000 f 0
W 00000008 00000906 f 0
W 0000000c 00000000 f 0
W 00000008 00000907 f 0
W 0000000c 00000000 f 0
W 00000008 00000908 f 0
W 0000000c 00000000 f 0
W 00000008 00000909 f 0
W 0000000c 00000000 f 0
R 0000001c 00000005 f 0
W 0000000c 00000000 f 2
R 00000018 00000901 f 0
R 00000010 ff001212 f 0
W 00000020 00000000 f 0
R 00000018 00000902 f 0
W 00000020 00000000 f 0
R 00000018 00000903 f 0
W 00000020 00000000 f 0
R 00000018 00000904 f 0
W 00000020 00000000 f 0
R 00000018 00000905 f 0
W 00000020 00000000 f 0
R 00000018 00000906 f 0
W 00000020 00000000 f 0
R 00000018 00000907 f 0
W 00000020 00000000 f 0
R 00000018 00000908 f 0
W 00000020 00000000 f 0
R 00000018 00000909 f 0
R 00000014 01020304 f 0
W 00000020 00000000 f 0
R 0000001c 00000000 f 0
